// File: zx_core.f
source/zx_bus_pkg.sv
source/zx_mem_pkg.sv
source/resetter.sv
source/zsignals.sv
source/zports.sv
source/zdos.sv
source/pager.sv
source/zx_top.sv
dv/zx_assertions.sv
dv/tb_zx_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_zx_top -f zx_core.f \
	--Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_zx_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qxF "=== PASS ===" sim.log && echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// File: dv/tb_zx_top.sv
`timescale 1ns/1ns

module tb_zx_top;

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	localparam int       RST_CNT_SIZE = 4;
	localparam int       ROUNDS       = 2;
	// bus cycles issued by the sequence below
	localparam int       BUS_CYCLES   = 6 * ROUNDS + 10;
	localparam z80_bus_t BUS_IDLE     = '1;

	logic        fclk;
	logic        reset;
	logic        soft_rst;
	z80_bus_t    bus;
	zaddr_t      a;
	wire  [7:0]  d;
	zdata_t      d_drv;
	logic        d_oe;
	logic        res;
	page_t       page;
	logic        romnram;
	logic        csrom;
	logic        beep;
	logic [31:0] seed = 32'h8a48_b295;
	int          errors;

	// expected register state
	page_t       exp_xt [4];
	zdata_t      exp_memconf;
	logic        exp_dos;

	assign d = d_oe ? d_drv : 8'bzzzz_zzzz;

	zx_top #(
		.RST_CNT_SIZE(RST_CNT_SIZE)
	) dut (
		.fclk    (fclk),
		.reset   (reset),
		.soft_rst(soft_rst),
		.bus     (bus),
		.a       (a),
		.d       (d),
		.res     (res),
		.page    (page),
		.romnram (romnram),
		.csrom   (csrom),
		.beep    (beep)
	);

	initial begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// window 0 holds ROM unless w0_ram is set
	function automatic page_t expected_page(input logic [1:0] win);
		if (win != 2'd0 || exp_memconf[3])
			return exp_xt[win];
		return {exp_xt[0][7:2], ~exp_dos, exp_memconf[0]};
	endfunction

	////////////////////////////////////////////////////////////
	// bus cycles, strobes held 3 cycles
	////////////////////////////////////////////////////////////
	task automatic io_write(input zaddr_t addr, input zdata_t data);
		@(posedge fclk);
		a          <= addr;
		d_drv      <= data;
		d_oe       <= 1'b1;
		bus.iorq_n <= 1'b0;
		bus.wr_n   <= 1'b0;
		repeat (3) @(posedge fclk);
		bus  <= BUS_IDLE;
		d_oe <= 1'b0;
	endtask

	task automatic io_read(input zaddr_t addr, input zdata_t exp_data);
		@(posedge fclk);
		a          <= addr;
		bus.iorq_n <= 1'b0;
		bus.rd_n   <= 1'b0;
		@(posedge fclk);
		@(negedge fclk);
		assert (d === exp_data) else begin
			$display("error d from port %h: got %h expected %h", addr, d, exp_data);
			errors++;
		end
		repeat (2) @(posedge fclk);
		bus <= BUS_IDLE;
	endtask

	task automatic op_fetch(input zaddr_t addr);
		@(posedge fclk);
		a          <= addr;
		bus.mreq_n <= 1'b0;
		bus.rd_n   <= 1'b0;
		bus.m1_n   <= 1'b0;
		repeat (3) @(posedge fclk);
		bus <= BUS_IDLE;
	endtask

	////////////////////////////////////////////////////////////
	// output checks
	////////////////////////////////////////////////////////////
	task automatic check_window(input logic [1:0] win);
		logic [31:0] r;
		page_t       exp_pg;
		logic        exp_rom;
		r       = next_random();
		exp_pg  = expected_page(win);
		exp_rom = (win == 2'd0) && !exp_memconf[3];
		@(posedge fclk);
		a <= {win, r[13:0]};
		@(negedge fclk);
		assert (page === exp_pg) else begin
			$display("error page at %h: got %h expected %h", a, page, exp_pg);
			errors++;
		end
		assert (romnram === exp_rom) else begin
			$display("error romnram at %h: got %h expected %h", a, romnram, exp_rom);
			errors++;
		end
		assert (csrom === exp_rom) else begin
			$display("error csrom at %h: got %h expected %h", a, csrom, exp_rom);
			errors++;
		end
	endtask

	task automatic check_beep(input logic exp_beep);
		@(negedge fclk);
		assert (beep === exp_beep) else begin
			$display("error beep: got %h expected %h", beep, exp_beep);
			errors++;
		end
	endtask

	task automatic count_res_high();
		int n;
		n = 0;
		@(negedge fclk);
		while (res && n < 64) begin
			n++;
			@(negedge fclk);
		end
		assert (n >= (1 << RST_CNT_SIZE) && !res) else begin
			$display("error res high cycles: got %h expected at least %h",
				n, 1 << RST_CNT_SIZE);
			errors++;
		end
	endtask

	initial begin
		logic [31:0] rnd;
		reset       = 1'b1;
		soft_rst    = 1'b0;
		bus         = BUS_IDLE;
		a           = '0;
		d_drv       = '0;
		d_oe        = 1'b0;
		errors      = 0;
		exp_xt      = '{8'h00, 8'h05, 8'h02, 8'h00};
		exp_memconf = '0;
		exp_dos     = 1'b0;

		repeat (16) @(posedge fclk);
		reset <= 1'b0;
		count_res_high();
		@(posedge fclk);
		soft_rst <= 1'b1;
		@(posedge fclk);
		soft_rst <= 1'b0;
		count_res_high();

		for (int w = 0; w < 4; w++)
			check_window(2'(w));

		// random window pages with readback
		for (int r = 0; r < ROUNDS; r++) begin
			for (int w = 1; w < 4; w++) begin
				rnd = next_random();
				io_write({6'b000100, 2'(w), 8'hAF}, rnd[15:8]);
				exp_xt[w] = rnd[15:8];
				check_window(2'(w));
				io_read({6'b000100, 2'(w), 8'hAF}, rnd[15:8]);
			end
		end

		// RAM in window 0, then back to ROM
		rnd = next_random();
		io_write(16'h10AF, rnd[23:16]);
		exp_xt[0] = rnd[23:16];
		io_write(16'h21AF, 8'h08);
		exp_memconf = 8'h08;
		check_window(2'd0);
		io_write(16'h21AF, 8'h01);
		exp_memconf = 8'h01;
		check_window(2'd0);
		io_read(16'h21AF, 8'h01);

		op_fetch({8'h3D, rnd[7:0]});
		exp_dos = 1'b1;
		check_window(2'd0);
		op_fetch(16'h8000);
		exp_dos = 1'b0;
		check_window(2'd0);

		io_write(16'h00FE, 8'h10);
		check_beep(1'b1);
		io_write(16'h00FF, 8'h00);
		check_beep(1'b1);
		io_write(16'h00FE, 8'h00);
		check_beep(1'b0);
		io_write(16'h00FF, 8'h10);
		check_beep(1'b0);

		@(posedge fclk);
		$display("errors: %0d testbench checks, %0d assertions", errors, dut.checks.fail_count);
		if (errors == 0 && dut.checks.fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		repeat (BUS_CYCLES * 5 + 200) @(posedge fclk);
		$display("timeout: test sequence did not finish in %0d cycles", BUS_CYCLES * 5 + 200);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: dv/zx_assertions.sv
`timescale 1ns/1ns

module zx_assertions (
	input logic                   fclk,
	input logic                   rst,
	input logic                   reset,
	input zx_bus_pkg::z80_bus_t   bus,
	input zx_bus_pkg::zaddr_t     a,
	input logic [7:0]             d,
	input zx_bus_pkg::z80_cycle_t cyc,
	input zx_mem_pkg::xt_page_t   xt_page,
	input logic                   dout_ena,
	input logic                   dos,
	input logic                   res,
	input logic                   romnram,
	input logic                   csrom,
	input logic                   beep
);

	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// reset and bus cycles
	////////////////////////////////////////////////////////////
	assert property (@(posedge fclk) reset |=> res)
	else begin
		$error("res did not rise after reset");
		fail_count++;
	end

	// level one cycle behind the strobes
	assert property (@(posedge fclk) disable iff (rst)
		cyc.iowr == $past(!bus.iorq_n && !bus.wr_n))
	else begin
		$error("I/O write level does not follow the bus strobes");
		fail_count++;
	end

	assert property (@(posedge fclk) disable iff (rst) cyc.iowr_s |=> !cyc.iowr_s)
	else begin
		$error("I/O write start pulse lasted more than one cycle");
		fail_count++;
	end

	// only memconf and the window pages are readable
	assert property (@(posedge fclk) disable iff (rst)
		dout_ena == (cyc.iord && a[7:0] == 8'hAF
			&& (a[15:10] == 6'b000100 || a[15:8] == 8'h21)))
	else begin
		$error("data bus enable does not match a read of a readable port");
		fail_count++;
	end

	////////////////////////////////////////////////////////////
	// registers and pins
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < 4; i++) begin : g_xtp
		assert property (@(posedge fclk) disable iff (rst)
			cyc.iowr_s && a == {6'b000100, 2'(i), 8'hAF} |=> xt_page[i] == $past(d))
		else begin
			$error("window %0d page register missed a write", i);
			fail_count++;
		end
	end

	assert property (@(posedge fclk) disable iff (rst)
		cyc.iowr_s && !a[0] |=> beep == $past(d[4]))
	else begin
		$error("beep does not match the border write");
		fail_count++;
	end

	// port #FF is odd, so the border must hold
	assert property (@(posedge fclk) disable iff (rst)
		cyc.iowr_s && a[7:0] == 8'hFF |=> $stable(beep))
	else begin
		$error("beep changed on a write to port FF");
		fail_count++;
	end

	assert property (@(posedge fclk) disable iff (rst) !cyc.opfetch_s |=> $stable(dos))
	else begin
		$error("dos flag changed without an opcode fetch");
		fail_count++;
	end

	// windows 1 to 3 are always RAM
	assert property (@(posedge fclk) disable iff (rst)
		a[15:14] != 2'b00 |-> !romnram && !csrom)
	else begin
		$error("ROM selected outside window 0");
		fail_count++;
	end

endmodule

bind zx_top zx_assertions checks (
	.fclk    (fclk),
	.rst     (rst),
	.reset   (reset),
	.bus     (bus),
	.a       (a),
	.d       (d),
	.cyc     (cyc),
	.xt_page (xt_page),
	.dout_ena(dout_ena),
	.dos     (dos),
	.res     (res),
	.romnram (romnram),
	.csrom   (csrom),
	.beep    (beep)
);

// File: source/zx_top.sv
`timescale 1ns/1ns

module zx_top #(
	parameter int RST_CNT_SIZE = 6
) (
	input  logic                 fclk,
	input  logic                 reset,
	input  logic                 soft_rst,
	input  zx_bus_pkg::z80_bus_t bus,
	input  zx_bus_pkg::zaddr_t   a,
	inout  wire  [7:0]           d,
	output logic                 res,
	output zx_mem_pkg::page_t    page,
	output logic                 romnram,
	output logic                 csrom,
	output logic                 beep
);

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	logic       rst;
	z80_cycle_t cyc;
	zdata_t     dout;
	logic       dout_ena;
	memconf_t   memconf;
	xt_page_t   xt_page;
	logic       dos;

	resetter #(
		.RST_CNT_SIZE(RST_CNT_SIZE)
	) resetter (
		.fclk    (fclk),
		.reset   (reset),
		.soft_rst(soft_rst),
		.rst     (rst)
	);

	zsignals zsignals (
		.fclk(fclk),
		.rst (rst),
		.bus (bus),
		.cyc (cyc)
	);

	zports zports (
		.fclk    (fclk),
		.rst     (rst),
		.cyc     (cyc),
		.a       (a),
		.din     (d),
		.dout    (dout),
		.dout_ena(dout_ena),
		.memconf (memconf),
		.xt_page (xt_page),
		.beep    (beep)
	);

	zdos zdos (
		.fclk   (fclk),
		.rst    (rst),
		.cyc    (cyc),
		.a      (a),
		.memconf(memconf),
		.dos    (dos)
	);

	pager pager (
		.a      (a),
		.memconf(memconf),
		.xt_page(xt_page),
		.dos    (dos),
		.page   (page),
		.romnram(romnram)
	);

	////////////////////////////////////////////////////////////
	// pins
	////////////////////////////////////////////////////////////
	assign d     = dout_ena ? dout : 8'bzzzz_zzzz;
	assign res   = rst;
	assign csrom = romnram;

endmodule

// File: source/pager.sv
`timescale 1ns/1ns

module pager (
	input  zx_bus_pkg::zaddr_t   a,
	input  zx_mem_pkg::memconf_t memconf,
	input  zx_mem_pkg::xt_page_t xt_page,
	input  logic                 dos,
	output zx_mem_pkg::page_t    page,
	output logic                 romnram
);

	logic [1:0] win;

	// 16k windows
	assign win = a[15:14];

	////////////////////////////////////////////////////////////
	// window to page
	////////////////////////////////////////////////////////////
	always_comb begin
		if (win != 2'd0 || memconf.w0_ram) begin
			page    = xt_page[win];
			romnram = 1'b0;
		end else begin
			// rom select: bit 1 is the 48k/dos pair, bit 0 the 128k half
			page    = {xt_page[0][7:2], ~dos, memconf.rom128};
			romnram = 1'b1;
		end
	end

endmodule

// File: source/zdos.sv
`timescale 1ns/1ns

module zdos (
	input  logic                   fclk,
	input  logic                   rst,
	input  zx_bus_pkg::z80_cycle_t cyc,
	input  zx_bus_pkg::zaddr_t     a,
	input  zx_mem_pkg::memconf_t   memconf,
	output logic                   dos
);

	import zx_mem_pkg::*;

	logic in_w0;
	logic rom_in_w0;

	assign in_w0     = (a[15:14] == 2'b00);
	assign rom_in_w0 = ~memconf.w0_ram & memconf.rom128;

	// flag follows opcode fetches only
	always_ff @(posedge fclk) begin
		if (rst) begin
			dos <= 1'b0;
		end else if (cyc.opfetch_s) begin
			if (!in_w0)
				dos <= 1'b0;
			else if (a[15:8] == DOS_ENTRY_HI && rom_in_w0)
				dos <= 1'b1;
		end
	end

endmodule

// File: source/zports.sv
`timescale 1ns/1ns

module zports (
	input  logic                   fclk,
	input  logic                   rst,
	input  zx_bus_pkg::z80_cycle_t cyc,
	input  zx_bus_pkg::zaddr_t     a,
	input  zx_bus_pkg::zdata_t     din,
	output zx_bus_pkg::zdata_t     dout,
	output logic                   dout_ena,
	output zx_mem_pkg::memconf_t   memconf,
	output zx_mem_pkg::xt_page_t   xt_page,
	output logic                   beep
);

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	port_id_e port_id;
	zdata_t   border;

	////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////
	always_comb begin
		if (!a[0]) begin
			port_id = port_border;
		end else begin
			case (a)
				PORT_XTP0:    port_id = port_xtp0;
				PORT_XTP1:    port_id = port_xtp1;
				PORT_XTP2:    port_id = port_xtp2;
				PORT_XTP3:    port_id = port_xtp3;
				PORT_SYSCONF: port_id = port_sysconf;
				PORT_MEMCONF: port_id = port_memconf;
				default:      port_id = port_none;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////
	always_ff @(posedge fclk) begin
		if (rst) begin
			border  <= '0;
			memconf <= '0;
			xt_page <= XT_PAGE_RST;
		end else if (cyc.iowr_s) begin
			case (port_id)
				port_border:  border <= din;
				port_memconf: memconf <= memconf_t'(din);
				// window index is the low bits of the high byte
				port_xtp0, port_xtp1, port_xtp2, port_xtp3:
					xt_page[a[9:8]] <= din;
				default: ;
			endcase
		end
	end

	assign beep = border[BEEP_BIT];

	// readback of memconf and the window pages
	always_comb begin
		dout     = '0;
		dout_ena = 1'b0;
		case (port_id)
			port_memconf: begin
				dout     = zdata_t'(memconf);
				dout_ena = cyc.iord;
			end
			port_xtp0, port_xtp1, port_xtp2, port_xtp3: begin
				dout     = xt_page[a[9:8]];
				dout_ena = cyc.iord;
			end
			default: ;
		endcase
	end

endmodule

// File: source/zsignals.sv
`timescale 1ns/1ns

module zsignals (
	input  logic                   fclk,
	input  logic                   rst,
	input  zx_bus_pkg::z80_bus_t   bus,
	output zx_bus_pkg::z80_cycle_t cyc
);

	// strobes after one register, active high
	logic iorq;
	logic mreq;
	logic rd;
	logic wr;
	logic m1;
	logic rfsh;

	// levels one cycle back
	logic iord_p;
	logic iowr_p;
	logic memwr_p;
	logic opfetch_p;

	always_ff @(posedge fclk) begin
		if (rst) begin
			iorq <= 1'b0;
			mreq <= 1'b0;
			rd   <= 1'b0;
			wr   <= 1'b0;
			m1   <= 1'b0;
			rfsh <= 1'b0;
		end else begin
			iorq <= ~bus.iorq_n;
			mreq <= ~bus.mreq_n;
			rd   <= ~bus.rd_n;
			wr   <= ~bus.wr_n;
			m1   <= ~bus.m1_n;
			rfsh <= ~bus.rfsh_n;
		end
	end

	always_comb begin
		cyc.iord      = iorq & rd;
		cyc.iowr      = iorq & wr;
		cyc.memrd     = mreq & rd;
		cyc.memwr     = mreq & wr;
		cyc.opfetch   = mreq & rd & m1 & ~rfsh;
		// first cycle of each level
		cyc.iord_s    = cyc.iord & ~iord_p;
		cyc.iowr_s    = cyc.iowr & ~iowr_p;
		cyc.memwr_s   = cyc.memwr & ~memwr_p;
		cyc.opfetch_s = cyc.opfetch & ~opfetch_p;
	end

	always_ff @(posedge fclk) begin
		if (rst) begin
			iord_p    <= 1'b0;
			iowr_p    <= 1'b0;
			memwr_p   <= 1'b0;
			opfetch_p <= 1'b0;
		end else begin
			iord_p    <= cyc.iord;
			iowr_p    <= cyc.iowr;
			memwr_p   <= cyc.memwr;
			opfetch_p <= cyc.opfetch;
		end
	end

endmodule

// File: source/resetter.sv
`timescale 1ns/1ns

module resetter #(
	parameter int RST_CNT_SIZE = 6
) (
	input  logic fclk,
	input  logic reset,
	input  logic soft_rst,
	output logic rst
);

	logic [RST_CNT_SIZE-1:0] cnt;

	// restart on either request, release once the counter saturates
	always_ff @(posedge fclk) begin
		if (reset || soft_rst) begin
			cnt <= '0;
			rst <= 1'b1;
		end else begin
			if (cnt != '1)
				cnt <= cnt + 1'b1;
			rst <= (cnt != '1);
		end
	end

endmodule

// File: source/zx_mem_pkg.sv
package zx_mem_pkg;

	typedef logic [7:0] page_t;

	// entry 0 is window #0000-#3FFF
	typedef page_t [3:0] xt_page_t;

	typedef struct packed {
		logic [3:0] spare_hi;
		logic       w0_ram;
		logic [1:0] spare_lo;
		logic       rom128;
	} memconf_t;

	////////////////////////////////////////////////////////////
	// port map
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		port_none,
		port_border,
		port_xtp0,
		port_xtp1,
		port_xtp2,
		port_xtp3,
		port_sysconf,
		port_memconf
	} port_id_e;

	// border #FE sits on any even address
	localparam logic [15:0] PORT_XTP0    = 16'h10AF;
	localparam logic [15:0] PORT_XTP1    = 16'h11AF;
	localparam logic [15:0] PORT_XTP2    = 16'h12AF;
	localparam logic [15:0] PORT_XTP3    = 16'h13AF;
	localparam logic [15:0] PORT_SYSCONF = 16'h20AF;
	localparam logic [15:0] PORT_MEMCONF = 16'h21AF;

	localparam xt_page_t    XT_PAGE_RST  = {8'd0, 8'd2, 8'd5, 8'd0};
	localparam logic [7:0]  DOS_ENTRY_HI = 8'h3D;
	localparam int          BEEP_BIT     = 4;

endpackage

// File: source/zx_bus_pkg.sv
package zx_bus_pkg;

	////////////////////////////////////////////////////////////
	// raw Z80 strobes, all active low
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic iorq_n;
		logic mreq_n;
		logic rd_n;
		logic wr_n;
		logic m1_n;
		logic rfsh_n;
	} z80_bus_t;

	// registered cycle levels and their start pulses
	typedef struct packed {
		logic iord;
		logic iowr;
		logic memrd;
		logic memwr;
		logic opfetch;
		logic iord_s;
		logic iowr_s;
		logic memwr_s;
		logic opfetch_s;
	} z80_cycle_t;

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

endpackage
